/* verilog/rvDecodePkg.sv */
package rvDecodePkg;

    localparam int XLEN    = 64;
    localparam int INSTR_W = 32;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_OP32    = 7'b0111011;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;

    // funct7 groups
    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // illegal sits at zero so a cleared record reads as no operation
    typedef enum logic [6:0] {
        OP_ILLEGAL,
        // register-register
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // M extension
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        // word forms
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW,
        // jumps and loads
        OP_JALR,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        // register-immediate
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        // stores and branches
        OP_SB, OP_SH, OP_SW, OP_SD,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // upper immediate and jal
        OP_LUI, OP_AUIPC, OP_JAL
    } rvOp_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } instrFmt_e;

    typedef struct packed {
        rvOp_e            op;
        instrFmt_e        fmt;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic             usesRs1;
        logic             usesRs2;
        logic             writesRd;
        logic             illegal;
        logic [XLEN-1:0]  imm;
    } decoded_t;

endpackage

/* verilog/opDecoder.sv */
`timescale 1ns/1ns

module opDecoder
    import rvDecodePkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    output rvOp_e              op,
    output instrFmt_e          fmt,
    output logic               usesRs1,
    output logic               usesRs2,
    output logic               writesRd,
    output logic               illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] shamtHi;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    // rv64 shifts keep shamt[5] in bit 25
    assign shamtHi = instr[31:26];

    always_comb begin
        op  = OP_ILLEGAL;
        fmt = FMT_NONE;
        case (opcode)
            OPC_OP: begin
                fmt = FMT_R;
                case (funct7)
                    F7_BASE: begin
                        case (funct3)
                            3'b000: op = OP_ADD;
                            3'b001: op = OP_SLL;
                            3'b010: op = OP_SLT;
                            3'b011: op = OP_SLTU;
                            3'b100: op = OP_XOR;
                            3'b101: op = OP_SRL;
                            3'b110: op = OP_OR;
                            default: op = OP_AND;
                        endcase
                    end
                    F7_ALT: begin
                        if (funct3 == 3'b000) op = OP_SUB;
                        else if (funct3 == 3'b101) op = OP_SRA;
                    end
                    F7_MULDIV: begin
                        case (funct3)
                            3'b000: op = OP_MUL;
                            3'b001: op = OP_MULH;
                            3'b010: op = OP_MULHSU;
                            3'b011: op = OP_MULHU;
                            3'b100: op = OP_DIV;
                            3'b101: op = OP_DIVU;
                            3'b110: op = OP_REM;
                            default: op = OP_REMU;
                        endcase
                    end
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_OP32: begin
                fmt = FMT_R;
                case (funct7)
                    F7_BASE: begin
                        if (funct3 == 3'b000) op = OP_ADDW;
                        else if (funct3 == 3'b001) op = OP_SLLW;
                        else if (funct3 == 3'b101) op = OP_SRLW;
                    end
                    F7_ALT: begin
                        if (funct3 == 3'b000) op = OP_SUBW;
                        else if (funct3 == 3'b101) op = OP_SRAW;
                    end
                    F7_MULDIV: begin
                        case (funct3)
                            3'b000: op = OP_MULW;
                            3'b100: op = OP_DIVW;
                            3'b101: op = OP_DIVUW;
                            3'b110: op = OP_REMW;
                            3'b111: op = OP_REMUW;
                            default: op = OP_ILLEGAL;
                        endcase
                    end
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_JALR: begin
                fmt = FMT_I;
                if (funct3 == 3'b000) op = OP_JALR;
            end
            OPC_LOAD: begin
                fmt = FMT_I;
                case (funct3)
                    3'b000: op = OP_LB;
                    3'b001: op = OP_LH;
                    3'b010: op = OP_LW;
                    3'b011: op = OP_LD;
                    3'b100: op = OP_LBU;
                    3'b101: op = OP_LHU;
                    3'b110: op = OP_LWU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_OPIMM: begin
                fmt = FMT_I;
                case (funct3)
                    3'b000: op = OP_ADDI;
                    3'b001: op = (shamtHi == 6'b000000) ? OP_SLLI : OP_ILLEGAL;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b101: begin
                        if (shamtHi == 6'b000000) op = OP_SRLI;
                        else if (shamtHi == 6'b010000) op = OP_SRAI;
                    end
                    3'b110: op = OP_ORI;
                    default: op = OP_ANDI;
                endcase
            end
            OPC_OPIMM32: begin
                fmt = FMT_I;
                case (funct3)
                    3'b000: op = OP_ADDIW;
                    3'b001: op = (funct7 == F7_BASE) ? OP_SLLIW : OP_ILLEGAL;
                    3'b101: begin
                        if (funct7 == F7_BASE) op = OP_SRLIW;
                        else if (funct7 == F7_ALT) op = OP_SRAIW;
                    end
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                fmt = FMT_S;
                case (funct3)
                    3'b000: op = OP_SB;
                    3'b001: op = OP_SH;
                    3'b010: op = OP_SW;
                    3'b011: op = OP_SD;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_BRANCH: begin
                fmt = FMT_B;
                case (funct3)
                    3'b000: op = OP_BEQ;
                    3'b001: op = OP_BNE;
                    3'b100: op = OP_BLT;
                    3'b101: op = OP_BGE;
                    3'b110: op = OP_BLTU;
                    3'b111: op = OP_BGEU;
                    default: op = OP_ILLEGAL;
                endcase
            end
            OPC_LUI: begin
                fmt = FMT_U;
                op  = OP_LUI;
            end
            OPC_AUIPC: begin
                fmt = FMT_U;
                op  = OP_AUIPC;
            end
            OPC_JAL: begin
                fmt = FMT_J;
                op  = OP_JAL;
            end
            default: op = OP_ILLEGAL;
        endcase
        // any undefined sub-encoding drops the format too
        if (op == OP_ILLEGAL) fmt = FMT_NONE;
    end

    always_comb begin
        usesRs1  = 1'b0;
        usesRs2  = 1'b0;
        writesRd = 1'b0;
        case (fmt)
            FMT_R: begin
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
                writesRd = 1'b1;
            end
            FMT_I: begin
                usesRs1  = 1'b1;
                writesRd = 1'b1;
            end
            FMT_S, FMT_B: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
            end
            FMT_U, FMT_J: writesRd = 1'b1;
            default: ;
        endcase
    end

    assign illegal = (fmt == FMT_NONE);

endmodule

/* verilog/immGen.sv */
`timescale 1ns/1ns

module immGen
    import rvDecodePkg::*;
(
    input  logic [INSTR_W-1:0] instr,
    input  instrFmt_e          fmt,
    input  rvOp_e              op,
    output logic [XLEN-1:0]    imm
);

    logic sign;
    logic isShift64;
    logic isShift32;

    assign sign = instr[31];

    // shift-immediates carry shamt, not a signed field
    assign isShift64 = (op == OP_SLLI) || (op == OP_SRLI) || (op == OP_SRAI);
    assign isShift32 = (op == OP_SLLIW) || (op == OP_SRLIW) || (op == OP_SRAIW);

    always_comb begin
        case (fmt)
            FMT_I: begin
                if (isShift64) begin
                    imm = {{(XLEN-6){1'b0}}, instr[25:20]};
                end else if (isShift32) begin
                    imm = {{(XLEN-5){1'b0}}, instr[24:20]};
                end else begin
                    imm = {{(XLEN-12){sign}}, instr[31:20]};
                end
            end
            FMT_S: begin
                imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            FMT_B: begin
                imm = {{(XLEN-13){sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            FMT_U: begin
                imm = {{(XLEN-32){sign}}, instr[31:12], 12'b0};
            end
            FMT_J: begin
                imm = {{(XLEN-21){sign}}, sign, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            // register formats and illegal encodings carry no immediate
            default: imm = '0;
        endcase
    end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ns

module decodeStage
    import rvDecodePkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  logic [INSTR_W-1:0] instr,
    output logic               outValid,
    output decoded_t           out
);

    rvOp_e           op;
    instrFmt_e       fmt;
    logic            usesRs1;
    logic            usesRs2;
    logic            writesRd;
    logic            illegal;
    logic [XLEN-1:0] imm;
    decoded_t        decodedNext;

    opDecoder opDec (
        .instr    (instr),
        .op       (op),
        .fmt      (fmt),
        .usesRs1  (usesRs1),
        .usesRs2  (usesRs2),
        .writesRd (writesRd),
        .illegal  (illegal)
    );

    immGen immGenInst (
        .instr (instr),
        .fmt   (fmt),
        .op    (op),
        .imm   (imm)
    );

    always_comb begin
        decodedNext.op       = op;
        decodedNext.fmt      = fmt;
        // register fields pass through even for illegal encodings
        decodedNext.rd       = instr[11:7];
        decodedNext.rs1      = instr[19:15];
        decodedNext.rs2      = instr[24:20];
        decodedNext.usesRs1  = usesRs1;
        decodedNext.usesRs2  = usesRs2;
        decodedNext.writesRd = writesRd;
        decodedNext.illegal  = illegal;
        decodedNext.imm      = imm;
    end

    // single pipeline register, one instruction per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            out      <= '0;
        end else begin
            outValid <= instrValid;
            // hold last record through gaps
            if (instrValid) begin
                out <= decodedNext;
            end
        end
    end

endmodule

/* dv/decodeChecker.sv */
`timescale 1ns/1ns

module decodeChecker
    import rvDecodePkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     instrValid,
    input  decoded_t expIn,
    input  logic     outValid,
    input  decoded_t out,
    output int       errorCount,
    output int       checkCount
);

    decoded_t expQ [$];
    decoded_t expected;
    // last record given out, zero out of reset
    decoded_t held = '0;
    logic     pendValid = 1'b0;

    task automatic compareField(input string name, input logic [XLEN-1:0] expVal,
                                input logic [XLEN-1:0] actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkRecord(input string tag, input decoded_t e);
        compareField({tag, ".op"}, 64'(e.op), 64'(out.op));
        compareField({tag, ".fmt"}, 64'(e.fmt), 64'(out.fmt));
        compareField({tag, ".rd"}, 64'(e.rd), 64'(out.rd));
        compareField({tag, ".rs1"}, 64'(e.rs1), 64'(out.rs1));
        compareField({tag, ".rs2"}, 64'(e.rs2), 64'(out.rs2));
        compareField({tag, ".usesRs1"}, 64'(e.usesRs1), 64'(out.usesRs1));
        compareField({tag, ".usesRs2"}, 64'(e.usesRs2), 64'(out.usesRs2));
        compareField({tag, ".writesRd"}, 64'(e.writesRd), 64'(out.writesRd));
        compareField({tag, ".illegal"}, 64'(e.illegal), 64'(out.illegal));
        compareField({tag, ".imm"}, e.imm, out.imm);
        checkCount++;
    endtask

    // outputs settle after the rising edge, so look on the falling one
    always @(negedge clk) begin
        if (outValid !== pendValid) begin
            if (pendValid) begin
                $display("outValid stayed low one cycle after an accepted instruction");
            end else begin
                $display("outValid went high with no instruction accepted the cycle before");
            end
            errorCount++;
        end
        if (pendValid) begin
            expected = expQ.pop_front();
            checkRecord("decode", expected);
            held = expected;
        end else begin
            checkRecord("hold", held);
        end
        // what the stage samples at the coming edge
        pendValid = instrValid && !rst;
        if (pendValid) begin
            expQ.push_back(expIn);
        end
    end

endmodule

/* dv/decodeTb.sv */
`timescale 1ns/1ns

module decodeTb
    import rvDecodePkg::*;
();

    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 3000;
    localparam int DRAIN_CYCLES = 4;
    // reset plus stimulus plus drain, with slack on top
    localparam int MAX_CYCLES   = RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES + 93;

    logic               clk = 1'b0;
    logic               rst;
    logic               instrValid;
    logic [INSTR_W-1:0] instr;
    logic               outValid;
    decoded_t           out;
    decoded_t           expIn;
    logic [31:0]        lfsr;
    int                 cycles = 0;
    int                 errorCount;
    int                 checkCount;

    decodeStage uut (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .outValid   (outValid),
        .out        (out)
    );

    decodeChecker chk (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .expIn      (expIn),
        .outValid   (outValid),
        .out        (out),
        .errorCount (errorCount),
        .checkCount (checkCount)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    function automatic logic [6:0] legalOpcode(input logic [3:0] sel);
        case (sel)
            4'd0: return OPC_OP;
            4'd1: return OPC_OP32;
            4'd2: return OPC_JALR;
            4'd3: return OPC_LOAD;
            4'd4: return OPC_OPIMM;
            4'd5: return OPC_OPIMM32;
            4'd6: return OPC_STORE;
            4'd7: return OPC_BRANCH;
            4'd8: return OPC_LUI;
            4'd9: return OPC_AUIPC;
            default: return OPC_JAL;
        endcase
    endfunction

    // step through a run of mnemonics that sit next to each other
    function automatic rvOp_e opAt(input rvOp_e base, input logic [2:0] idx);
        return rvOp_e'(base + {4'b0, idx});
    endfunction

    function automatic decoded_t refDecode(input logic [31:0] i);
        decoded_t        d;
        rvOp_e           op;
        instrFmt_e       fmt;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] imm;
        f3 = i[14:12];
        f7 = i[31:25];
        immI = {{52{i[31]}}, i[31:20]};
        op = OP_ILLEGAL;
        fmt = FMT_NONE;
        imm = '0;
        case (i[6:0])
            OPC_OP: begin
                fmt = FMT_R;
                if (f7 == 7'b0000001) op = opAt(OP_MUL, f3);
                else if (f7 == 7'b0100000 && f3 == 3'd0) op = OP_SUB;
                else if (f7 == 7'b0100000 && f3 == 3'd5) op = OP_SRA;
                else if (f7 == 7'b0000000 && f3 == 3'd0) op = OP_ADD;
                else if (f7 == 7'b0000000 && f3 <= 3'd5) op = opAt(OP_SLL, f3 - 3'd1);
                else if (f7 == 7'b0000000) op = opAt(OP_OR, f3 - 3'd6);
            end
            OPC_OP32: begin
                fmt = FMT_R;
                if (f7 == 7'b0000001 && f3 == 3'd0) op = OP_MULW;
                else if (f7 == 7'b0000001 && f3[2]) op = opAt(OP_DIVW, f3 - 3'd4);
                else if (f7 == 7'b0000000 && f3 == 3'd0) op = OP_ADDW;
                else if (f7 == 7'b0000000 && f3 == 3'd1) op = OP_SLLW;
                else if (f7 == 7'b0000000 && f3 == 3'd5) op = OP_SRLW;
                else if (f7 == 7'b0100000 && f3 == 3'd0) op = OP_SUBW;
                else if (f7 == 7'b0100000 && f3 == 3'd5) op = OP_SRAW;
            end
            OPC_JALR: begin
                fmt = FMT_I;
                imm = immI;
                if (f3 == 3'd0) op = OP_JALR;
            end
            OPC_LOAD: begin
                fmt = FMT_I;
                imm = immI;
                if (f3 != 3'd7) op = opAt(OP_LB, f3);
            end
            OPC_OPIMM: begin
                fmt = FMT_I;
                imm = immI;
                if (f3 == 3'd0) op = OP_ADDI;
                else if (f3 >= 3'd2 && f3 <= 3'd4) op = opAt(OP_SLTI, f3 - 3'd2);
                else if (f3 >= 3'd6) op = opAt(OP_ORI, f3 - 3'd6);
                else if (i[31:26] == 6'b000000) op = (f3 == 3'd1) ? OP_SLLI : OP_SRLI;
                else if (i[31:26] == 6'b010000 && f3 == 3'd5) op = OP_SRAI;
                // six-bit shamt on rv64
                if (f3 == 3'd1 || f3 == 3'd5) imm = {58'b0, i[25:20]};
            end
            OPC_OPIMM32: begin
                fmt = FMT_I;
                imm = immI;
                if (f3 == 3'd0) op = OP_ADDIW;
                else if (f3 == 3'd1 && f7 == 7'b0000000) op = OP_SLLIW;
                else if (f3 == 3'd5 && f7 == 7'b0000000) op = OP_SRLIW;
                else if (f3 == 3'd5 && f7 == 7'b0100000) op = OP_SRAIW;
                if (f3 == 3'd1 || f3 == 3'd5) imm = {59'b0, i[24:20]};
            end
            OPC_STORE: begin
                fmt = FMT_S;
                imm = {{52{i[31]}}, i[31:25], i[11:7]};
                if (!f3[2]) op = opAt(OP_SB, f3);
            end
            OPC_BRANCH: begin
                fmt = FMT_B;
                imm = {{51{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
                if (f3 <= 3'd1) op = opAt(OP_BEQ, f3);
                else if (f3[2]) op = opAt(OP_BLT, f3 - 3'd4);
            end
            OPC_LUI, OPC_AUIPC: begin
                fmt = FMT_U;
                imm = {{32{i[31]}}, i[31:12], 12'b0};
                op = (i[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
            end
            OPC_JAL: begin
                fmt = FMT_J;
                imm = {{43{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
                op = OP_JAL;
            end
            default: op = OP_ILLEGAL;
        endcase
        if (op == OP_ILLEGAL) begin
            fmt = FMT_NONE;
            imm = '0;
        end
        d = '0;
        d.op = op;
        d.fmt = fmt;
        d.rd = i[11:7];
        d.rs1 = i[19:15];
        d.rs2 = i[24:20];
        d.usesRs1 = fmt inside {FMT_R, FMT_I, FMT_S, FMT_B};
        d.usesRs2 = fmt inside {FMT_R, FMT_S, FMT_B};
        d.writesRd = fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
        d.illegal = (op == OP_ILLEGAL);
        d.imm = imm;
        return d;
    endfunction

    initial begin
        logic [31:0] r;
        logic [3:0]  sel;
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [31:0] word;
        logic        valid;
        rst <= 1'b1;
        instrValid <= 1'b0;
        instr <= '0;
        expIn <= '0;
        lfsr = 32'h4b33;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NUM_CYCLES; n++) begin
            // valid three cycles in four
            takeBits(2, r);
            valid = (r[1:0] != 2'b00);
            takeBits(4, r);
            sel = r[3:0];
            if (sel < 4'd11) begin
                opc = legalOpcode(sel);
            end else begin
                takeBits(7, r);
                opc = r[6:0];
            end
            takeBits(2, r);
            case (r[1:0])
                2'd0: f7 = 7'b0000000;
                2'd1: f7 = 7'b0100000;
                2'd2: f7 = 7'b0000001;
                default: begin
                    takeBits(7, r);
                    f7 = r[6:0];
                end
            endcase
            // rs2, rs1, funct3 and rd
            takeBits(18, r);
            word = {f7, r[17:0], opc};
            instrValid <= valid;
            instr <= word;
            expIn <= refDecode(word);
            @(posedge clk);
        end
        instrValid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("decode checks: %0d records compared, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/rvDecodePkg.sv
verilog/opDecoder.sv
verilog/immGen.sv
verilog/decodeStage.sv
dv/decodeChecker.sv
dv/decodeTb.sv

/* run.sh */
#!/bin/sh
# build the decode stage testbench with Verilator, run it, then look for the pass line
verilator --binary --top-module decodeTb -f sources.f -o decodeSim > build.log 2>&1 \
    && ./obj_dir/decodeSim > sim.log 2>&1 \
    && grep -q "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
